/* source/dcache_pkg.sv */
package dcache_pkg;

	// ##############################
	// cache geometry
	// ##############################

	localparam int N_PORTS = 2; // core ports, one cache each
	localparam int LINES = 16; // lines per cache
	localparam int WORDS_PER_LINE = 16; // 64 byte lines of 32-bit words

	// byte address split is [31 tag 10] [9 line 6] [5 word 2] [1 byte 0]
	localparam int WORD_LSB = 2;
	localparam int IDX_LSB = 6;
	localparam int TAG_LSB = 10;

	localparam int PORT_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1; // never zero wide

	// ##############################
	// types
	// ##############################

	typedef logic [31:0] word_t; // one data word
	typedef logic [31:0] addr_t; // byte address
	typedef logic [31:TAG_LSB] tag_t; // 22-bit tag
	typedef logic [IDX_LSB-1:WORD_LSB] word_idx_t; // word within a line
	typedef logic [TAG_LSB-1:IDX_LSB] line_idx_t; // line within a cache
	typedef logic [PORT_W-1:0] port_id_t; // names one port

	typedef enum logic {
		arb_idle, // no owner, bus strobes low
		arb_busy // one cache owns the memory bus
	} arb_state_t;

endpackage

/* source/cache_bus_if.sv */
`timescale 1ns/10ps

interface cache_bus_if import dcache_pkg::*; ();

	// ##############################
	// cache to arbiter
	// ##############################

	logic bus_req; // held while a read miss or write is pending
	addr_t bus_addr; // word address of the current beat
	word_t bus_wdata; // write data of the current beat
	logic bus_rd; // read beat, only while bus_ack
	logic bus_wr; // write beat, only while bus_ack

	// ##############################
	// arbiter to cache
	// ##############################

	logic bus_ack; // this cache owns the bus
	word_t bus_rdata; // read data, valid with bus_ready
	logic bus_ready; // current beat completes this cycle
	logic snoop_valid; // another port completed a write
	addr_t snoop_addr; // address of that write

	modport cache (
		output bus_req,
		output bus_addr,
		output bus_wdata,
		output bus_rd,
		output bus_wr,
		input bus_ack,
		input bus_rdata,
		input bus_ready,
		input snoop_valid,
		input snoop_addr
	);

	modport arbiter (
		input bus_req,
		input bus_addr,
		input bus_wdata,
		input bus_rd,
		input bus_wr,
		output bus_ack,
		output bus_rdata,
		output bus_ready,
		output snoop_valid,
		output snoop_addr
	);

endinterface

/* source/dcache_line_store.sv */
`timescale 1ns/10ps

module dcache_line_store import dcache_pkg::*; (
	input logic clk,
	input logic reset,

	input addr_t addr,
	input logic rd_req,
	input logic wr_req,
	input word_t wr_data,
	output logic rw_wait,
	output word_t rd_data,

	cache_bus_if.cache bus
);

	// ##############################
	// storage
	// ##############################

	logic [LINES-1:0] line_valid; // one valid bit per line
	tag_t line_tag [LINES];
	word_t line_data [LINES][WORDS_PER_LINE];

	word_idx_t fill_pos; // next word of the line being filled

	// ##############################
	// address decode and hit
	// ##############################

	tag_t tag;
	line_idx_t idx;
	word_idx_t word;
	tag_t snoop_tag;
	line_idx_t snoop_idx;

	logic cache_hit;
	logic read_miss;
	logic fill_beat;
	logic write_beat;
	logic snoop_hit;

	assign tag = addr[31:TAG_LSB];
	assign idx = addr[TAG_LSB-1:IDX_LSB];
	assign word = addr[IDX_LSB-1:WORD_LSB];
	assign snoop_tag = bus.snoop_addr[31:TAG_LSB];
	assign snoop_idx = bus.snoop_addr[TAG_LSB-1:IDX_LSB];

	assign cache_hit = line_valid[idx] && (line_tag[idx] == tag);
	assign read_miss = rd_req && !cache_hit;

	assign fill_beat = bus.bus_rd && bus.bus_ready; // a fill word arrives
	assign write_beat = bus.bus_wr && bus.bus_ready; // the write reached memory

	// only a valid line with a matching tag is dropped
	assign snoop_hit = bus.snoop_valid && line_valid[snoop_idx]
		&& (line_tag[snoop_idx] == snoop_tag);

	// ##############################
	// core side
	// ##############################

	assign rd_data = line_data[idx][word]; // valid on a hit, same cycle
	assign rw_wait = read_miss || (wr_req && !write_beat);

	// ##############################
	// bus side
	// ##############################

	assign bus.bus_req = read_miss || wr_req;

	always_comb begin
		bus.bus_rd = 1'b0;
		bus.bus_wr = 1'b0;
		bus.bus_addr = '0;
		bus.bus_wdata = '0;
		if (read_miss && bus.bus_ack) begin
			bus.bus_addr = {addr[31:IDX_LSB], fill_pos, 2'b00}; // whole words only
			bus.bus_rd = 1'b1;
		end else if (wr_req && bus.bus_ack) begin
			bus.bus_addr = addr;
			bus.bus_wdata = wr_data;
			bus.bus_wr = 1'b1;
		end
	end

	// ##############################
	// control state
	// ##############################

	always_ff @(posedge clk) begin
		if (reset) begin
			line_valid <= '0;
			fill_pos <= '0;
		end else begin
			if (!read_miss)
				fill_pos <= '0; // the next miss starts at word 0
			else if (fill_beat)
				fill_pos <= fill_pos + 1'b1; // wraps to 0 after word 15
			if (fill_beat && (fill_pos == word_idx_t'(WORDS_PER_LINE - 1)))
				line_valid[idx] <= 1'b1; // last word landed
			// snoops only come from another owner, so they never meet a fill here
			if (snoop_hit)
				line_valid[snoop_idx] <= 1'b0;
		end
	end

	// ##############################
	// tags and data
	// ##############################

	always_ff @(posedge clk) begin
		if (fill_beat) begin
			line_data[idx][fill_pos] <= bus.bus_rdata;
			if (fill_pos == word_idx_t'(WORDS_PER_LINE - 1))
				line_tag[idx] <= tag;
		end else if (write_beat && cache_hit) begin
			line_data[idx][word] <= wr_data; // write-through hit keeps the copy current
		end
	end

endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter import dcache_pkg::*; (
	input logic clk,
	input logic reset,

	output addr_t mem_addr,
	output word_t mem_wdata,
	output logic mem_rd,
	output logic mem_wr,
	input word_t mem_rdata,
	input logic mem_ready,

	cache_bus_if.arbiter bus [N_PORTS]
);

	arb_state_t state;
	arb_state_t next_state;
	port_id_t owner; // current owner, or the last one while idle
	port_id_t next_owner;

	logic [N_PORTS-1:0] req;
	logic [N_PORTS-1:0] rd_v;
	logic [N_PORTS-1:0] wr_v;
	addr_t addr_v [N_PORTS];
	word_t wdata_v [N_PORTS];

	logic busy;
	logic write_done;

	// ##############################
	// per-port wiring
	// ##############################

	for (genvar i = 0; i < N_PORTS; i++) begin : g_port
		logic is_owner;

		assign is_owner = busy && (owner == port_id_t'(i));

		assign req[i] = bus[i].bus_req;
		assign rd_v[i] = bus[i].bus_rd;
		assign wr_v[i] = bus[i].bus_wr;
		assign addr_v[i] = bus[i].bus_addr;
		assign wdata_v[i] = bus[i].bus_wdata;

		assign bus[i].bus_ack = is_owner;
		assign bus[i].bus_ready = is_owner && mem_ready; // others just keep waiting
		assign bus[i].bus_rdata = is_owner ? mem_rdata : '0;
		assign bus[i].snoop_valid = write_done && !is_owner; // everyone but the writer
		assign bus[i].snoop_addr = mem_addr;
	end

	// ##############################
	// memory bus mux
	// ##############################

	assign busy = (state == arb_busy);

	assign mem_addr = addr_v[owner];
	assign mem_wdata = wdata_v[owner];
	assign mem_rd = busy && rd_v[owner];
	assign mem_wr = busy && wr_v[owner];

	assign write_done = mem_wr && mem_ready;

	// ##############################
	// round-robin grant
	// ##############################

	always_comb begin
		int cand;
		logic found;
		next_state = state;
		next_owner = owner;
		found = 1'b0;
		cand = 0;
		if (!busy || !req[owner]) begin
			next_state = arb_idle;
			for (int k = 1; k <= N_PORTS; k++) begin
				cand = (int'(owner) + k) % N_PORTS; // start after the last owner
				if (!found && req[cand]) begin
					found = 1'b1;
					next_owner = port_id_t'(cand);
					next_state = arb_busy;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= arb_idle;
			owner <= port_id_t'(N_PORTS - 1); // first search begins at port 0
		end else begin
			state <= next_state;
			owner <= next_owner;
		end
	end

endmodule

/* source/shared_dcache.sv */
`timescale 1ns/10ps

module shared_dcache import dcache_pkg::*; (
	input logic clk,
	input logic reset,

	// ##############################
	// core ports
	// ##############################
	input addr_t core_addr [N_PORTS],
	input logic core_rd_req [N_PORTS],
	input logic core_wr_req [N_PORTS],
	input word_t core_wr_data [N_PORTS],
	output logic core_rw_wait [N_PORTS],
	output word_t core_rd_data [N_PORTS],

	// ##############################
	// memory bus
	// ##############################
	output addr_t mem_addr,
	output word_t mem_wdata,
	output logic mem_rd,
	output logic mem_wr,
	input word_t mem_rdata,
	input logic mem_ready
);

	cache_bus_if cbus [N_PORTS] (); // one link per cache

	for (genvar i = 0; i < N_PORTS; i++) begin : g_cache
		dcache_line_store u_cache (
			.clk (clk),
			.reset (reset),
			.addr (core_addr[i]),
			.rd_req (core_rd_req[i]),
			.wr_req (core_wr_req[i]),
			.wr_data (core_wr_data[i]),
			.rw_wait (core_rw_wait[i]),
			.rd_data (core_rd_data[i]),
			.bus (cbus[i])
		);
	end

	// single owner of the memory bus, also the snoop source
	bus_arbiter u_arbiter (
		.clk (clk),
		.reset (reset),
		.mem_addr (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rd (mem_rd),
		.mem_wr (mem_wr),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready),
		.bus (cbus)
	);

endmodule

/* bench/shared_dcache_checker.sv */
`timescale 1ns/10ps

module shared_dcache_checker import dcache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic mem_rd,
	input logic mem_wr,
	input addr_t mem_addr,
	input logic core_rw_wait [N_PORTS]
);

	int wait_cnt [N_PORTS]; // consecutive wait cycles per port
	int longest_wait;
	int clash_fails = 0;
	int align_fails = 0;
	int wait_fails = 0;
	int reset_fails = 0;
	int fail_total;

	assign fail_total = clash_fails + align_fails + wait_fails + reset_fails;

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_PORTS; i++) begin
			if (reset || !core_rw_wait[i])
				wait_cnt[i] <= 0;
			else
				wait_cnt[i] <= wait_cnt[i] + 1;
		end
	end

	always_comb begin
		longest_wait = 0;
		for (int i = 0; i < N_PORTS; i++)
			if (wait_cnt[i] > longest_wait)
				longest_wait = wait_cnt[i];
	end

	// ##############################
	// bus protocol
	// ##############################

	assert property (@(posedge clk) disable iff (reset) !(mem_rd && mem_wr))
	else begin
		$error("mem_rd and mem_wr high together");
		clash_fails++;
	end

	assert property (@(posedge clk) disable iff (reset) mem_rd |-> (mem_addr[1:0] == 2'b00))
	else begin
		$error("read beat address not word aligned");
		align_fails++;
	end

	// two fills plus a write at a slow memory still fit well inside this
	assert property (@(posedge clk) disable iff (reset)
		longest_wait <= N_PORTS * (WORDS_PER_LINE + 1) * 8)
	else begin
		$error("a core waited past the bound");
		wait_fails++;
	end

	assert property (@(posedge clk) $fell(reset) |-> (!mem_rd && !mem_wr))
	else begin
		$error("memory strobe high right after reset");
		reset_fails++;
	end

endmodule

bind shared_dcache shared_dcache_checker checker0 (
	.clk (clk),
	.reset (reset),
	.mem_rd (mem_rd),
	.mem_wr (mem_wr),
	.mem_addr (mem_addr),
	.core_rw_wait (core_rw_wait)
);

/* bench/shared_dcache_tb.sv */
`timescale 1ns/10ps

module shared_dcache_tb import dcache_pkg::*; ();

	logic clk = 1'b0;
	logic reset;
	addr_t core_addr [N_PORTS];
	logic core_rd_req [N_PORTS];
	logic core_wr_req [N_PORTS];
	word_t core_wr_data [N_PORTS];
	logic core_rw_wait [N_PORTS];
	word_t core_rd_data [N_PORTS];
	addr_t mem_addr;
	word_t mem_wdata;
	logic mem_rd;
	logic mem_wr;
	word_t mem_rdata;
	logic mem_ready;

	word_t mem_store [addr_t]; // only written words live here
	addr_t read_beats [$]; // addresses of completed read beats
	addr_t last_wr_addr;
	word_t last_wr_data;
	logic [31:0] lfsr_state = 32'h429c_e0b7;
	int test_accesses [6] = '{1, 17, 3, 3, 2, 8}; // accesses per test, idle test counts as one
	int cycle_count = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int errors_at_start = 0;

	shared_dcache dut0 (.*);

	// ##############################
	// clock, memory and watchdog
	// ##############################

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	function automatic word_t mem_read(input addr_t a);
		addr_t w;
		w = {a[31:2], 2'b00};
		if (mem_store.exists(w))
			return mem_store[w];
		return w ^ 32'h5a5a_0000; // untouched words follow the address
	endfunction

	function automatic int timeout_cycles();
		int sum;
		sum = 0;
		foreach (test_accesses[i])
			sum += test_accesses[i];
		return 20 * sum * (WORDS_PER_LINE + 1); // one fill plus one write per access
	endfunction

	function automatic int wait_bound();
		return N_PORTS * (WORDS_PER_LINE + 1) * 8;
	endfunction

	function automatic int total_errors();
		return errors + dut0.checker0.fail_total;
	endfunction

	always @(posedge clk) begin
		#2;
		lfsr_state = lfsr_next(lfsr_state);
		mem_ready = lfsr_state[0]; // one new bit per cycle
	end

	// the bus is stable at the falling edge
	always @(negedge clk) begin
		if (mem_rd && mem_ready)
			read_beats.push_back(mem_addr);
		if (mem_wr && mem_ready) begin
			mem_store[{mem_addr[31:2], 2'b00}] = mem_wdata;
			last_wr_addr = mem_addr;
			last_wr_data = mem_wdata;
		end
		mem_rdata <= mem_read(mem_addr); // held until the sampling edge
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles()) begin
			$display("timeout after %0d cycles, a request never completed", cycle_count);
			$display("sim failed");
			$finish;
		end
	end

	// ##############################
	// checks and accesses
	// ##############################

	task automatic check_word(input string name, input word_t exp, input word_t got);
		checks++;
		assert (got == exp) else begin
			$display("Error: %0d ns %s expected %h actual %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			$display("%0d ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, total_errors() - errors_at_start);
		errors_at_start = total_errors();
	endtask

	// one read or write on port p, returns the read word and the cycles spent waiting
	task automatic run_access(input int p, input logic wr, input addr_t a, input word_t d,
			output word_t rdata, output int waited);
		int n;
		n = 0;
		@(posedge clk);
		#2;
		core_addr[p] = a;
		core_wr_data[p] = d;
		core_rd_req[p] = !wr;
		core_wr_req[p] = wr;
		@(negedge clk);
		while (core_rw_wait[p]) begin
			n++;
			@(negedge clk);
		end
		rdata = core_rd_data[p];
		waited = n;
		if (!wr)
			check_word($sformatf("core_rd_data[%0d]", p), mem_read(a), rdata);
		@(posedge clk);
		#2;
		core_rd_req[p] = 1'b0;
		core_wr_req[p] = 1'b0;
	endtask

	// ##############################
	// tests
	// ##############################

	initial begin
		word_t rd;
		word_t rd_b;
		int waited;
		int waited_b;
		addr_t base;
		reset = 1'b1;
		mem_ready = 1'b0;
		mem_rdata = '0;
		for (int p = 0; p < N_PORTS; p++) begin
			core_addr[p] = '0;
			core_rd_req[p] = 1'b0;
			core_wr_req[p] = 1'b0;
			core_wr_data[p] = '0;
		end
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;

		repeat (2) @(negedge clk);
		check_true(!mem_rd && !mem_wr, "memory strobes high with no request");
		for (int p = 0; p < N_PORTS; p++)
			check_true(!core_rw_wait[p], "rw_wait high with no request");
		finish_test("idle");

		base = 32'h0000_1040; // line 1
		read_beats.delete();
		run_access(0, 1'b0, base, '0, rd, waited);
		check_true(read_beats.size() == WORDS_PER_LINE, "fill did not take one beat per word");
		foreach (read_beats[k])
			check_word("mem_addr", base + addr_t'(4 * k), read_beats[k]);
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			run_access(0, 1'b0, base + addr_t'(4 * k), '0, rd, waited);
			check_true(waited == 0, "port 0 waited on a read hit");
		end
		finish_test("fill");

		run_access(0, 1'b1, base + 32'd8, 32'hc0de_0003, rd, waited);
		check_word("mem_addr", base + 32'd8, last_wr_addr);
		check_word("mem_wdata", 32'hc0de_0003, last_wr_data);
		run_access(0, 1'b0, base + 32'd8, '0, rd, waited);
		check_word("core_rd_data[0]", 32'hc0de_0003, rd);
		run_access(1, 1'b0, base + 32'd8, '0, rd, waited);
		check_word("core_rd_data[1]", 32'hc0de_0003, rd);
		finish_test("write");

		base = 32'h0000_2280;
		run_access(0, 1'b0, base + 32'd12, '0, rd, waited); // port 0 now holds the line
		run_access(1, 1'b1, base + 32'd12, 32'hfeed_0004, rd, waited);
		run_access(0, 1'b0, base + 32'd12, '0, rd, waited);
		check_word("core_rd_data[0]", 32'hfeed_0004, rd);
		finish_test("snoop");

		fork
			run_access(0, 1'b0, 32'h0000_3100, '0, rd, waited);
			run_access(1, 1'b0, 32'h0000_4300, '0, rd_b, waited_b);
		join
		check_true(waited <= wait_bound() && waited_b <= wait_bound(),
			"a port waited past the bound");
		finish_test("arbitration");

		// same line index 6, different tags
		for (int k = 0; k < 8; k++) begin
			base = (k % 2 == 1) ? 32'h0000_9180 : 32'h0000_5180;
			run_access(0, 1'b0, base + addr_t'(4 * k), '0, rd, waited);
		end
		finish_test("alias");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, total_errors());
		if (total_errors() == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* project.f */
source/dcache_pkg.sv
source/cache_bus_if.sv
source/dcache_line_store.sv
source/bus_arbiter.sv
source/shared_dcache.sv
bench/shared_dcache_checker.sv
bench/shared_dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= shared_dcache_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
